//--- design/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 32;
    localparam int REG_BITS = 4;
    localparam int NUM_REGS = 2 ** REG_BITS;
    localparam int OPC_BITS = 5;
    localparam int IMM_BITS = 12;
    localparam int DEFAULT_CLK_DIV = 2;

    typedef enum logic [OPC_BITS-1:0] {
        op_nop   = 5'd0,
        op_add   = 5'd1,
        op_sub   = 5'd2,
        op_and   = 5'd3,
        op_xor   = 5'd4,
        op_addi  = 5'd5,
        op_sleep = 5'd6,
        op_halt  = 5'd7
    } opcode_t;

    // Instruction word with the opcode in the top bits.
    typedef struct packed {
        logic [OPC_BITS-1:0] opcode;   // Bits 31..27.
        logic [REG_BITS-1:0] rd;       // Bits 26..23.
        logic [REG_BITS-1:0] rs1;      // Bits 22..19.
        logic [REG_BITS-1:0] rs2;      // Bits 18..15.
        logic [2:0]          spare;
        logic [IMM_BITS-1:0] imm;      // Signed.
    } instr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_word_t;

    typedef struct packed {
        logic                valid;
        logic [REG_BITS-1:0] rd;
        logic [XLEN-1:0]     data;
    } wb_word_t;

    typedef struct packed {
        logic                valid;
        logic [XLEN-1:0]     pc;
        logic [REG_BITS-1:0] rd;
        logic [XLEN-1:0]     data;
    } retire_t;

    typedef enum logic [1:0] {
        st_run   = 2'd0,
        st_sleep = 2'd1,
        st_halt  = 2'd2
    } ctrl_state_t;

endpackage

//--- design/enable_timer.sv
module enable_timer #(
    parameter int CLK_DIV = cpu_pkg::DEFAULT_CLK_DIV
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     halted,
    output logic                     clk_en,
    output logic [cpu_pkg::XLEN-1:0] cycles
);

    localparam int DIV_BITS = (CLK_DIV > 0) ? $clog2(CLK_DIV + 1) : 1;

    logic [DIV_BITS-1:0] div_count;

    // One pulse every CLK_DIV+1 clocks.
    always_ff @(posedge clk) begin
        if (reset) begin
            div_count <= '0;
            clk_en <= 1'b0;
        end else if (div_count == DIV_BITS'(CLK_DIV)) begin
            div_count <= '0;
            clk_en <= 1'b1;
        end else begin
            div_count <= div_count + 1'b1;
            clk_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cycles <= '0;
        end else if (clk_en && !halted) begin
            cycles <= cycles + 1'b1;   // Frozen once halted.
        end
    end

    if (CLK_DIV > 0) begin : g_pace_check
        // Pulses are spaced by at least the divider period.
        assert property (@(posedge clk) disable iff (reset)
            clk_en |=> (!clk_en) [*CLK_DIV]);
    end

endmodule

//--- design/core_control.sv
module core_control (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_en,
    input  logic        is_sleep,
    input  logic        is_halt,
    input  logic [15:0] interrupts,
    output logic        advance,
    output logic        writeback_advance,
    output logic        flush_fetch,
    output logic        sleeping,
    output logic        halted
);
    import cpu_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_run: begin
                if (is_halt) begin
                    state_next = st_halt;
                end else if (is_sleep) begin
                    state_next = st_sleep;
                end
            end
            st_sleep: begin
                // Any pending interrupt line wakes the core.
                if (interrupts != '0) begin
                    state_next = st_run;
                end
            end
            default: begin
                state_next = st_halt;   // Left only through reset.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_run;
        end else if (clk_en) begin
            state <= state_next;
        end
    end

    // Fetch and execute move only while running.
    assign advance = clk_en && (state == st_run);

    // Writeback drains on every pulse.
    assign writeback_advance = clk_en;

    assign flush_fetch = advance && (is_sleep || is_halt);

    assign sleeping = (state == st_sleep);
    assign halted   = (state == st_halt);

    assert property (@(posedge clk) disable iff (reset)
        !(sleeping && halted));

endmodule

//--- design/fetch_stage.sv
module fetch_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     advance,
    input  logic                     flush_fetch,
    input  logic [cpu_pkg::XLEN-1:0] redirect_pc,
    output logic [cpu_pkg::XLEN-1:0] imem_addr,
    input  logic [cpu_pkg::XLEN-1:0] imem_data,
    output cpu_pkg::fetch_word_t     fetch_word
);
    import cpu_pkg::*;

    logic [XLEN-1:0] pc;

    // Memory answers in the same cycle.
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            fetch_word <= '0;
        end else if (advance) begin
            if (flush_fetch) begin
                // Drop the younger word and restart at the redirect.
                pc <= redirect_pc;
                fetch_word.valid <= 1'b0;
            end else begin
                pc <= pc + 1'b1;   // Word addressed.
                fetch_word <= '{valid: 1'b1, pc: pc, instr: imem_data};
            end
        end
    end

endmodule

//--- design/execute_stage.sv
module execute_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     advance,
    input  cpu_pkg::fetch_word_t     fetch_word,
    input  cpu_pkg::wb_word_t        reg_write,
    output cpu_pkg::wb_word_t        wb_word,
    output logic                     is_sleep,
    output logic                     is_halt,
    output logic [cpu_pkg::XLEN-1:0] redirect_pc
);
    import cpu_pkg::*;

    instr_t          instr;
    opcode_t         opcode;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            writes_reg;

    assign instr   = instr_t'(fetch_word.instr);
    assign opcode  = opcode_t'(instr.opcode);
    assign imm_ext = {{(XLEN - IMM_BITS){instr.imm[IMM_BITS-1]}}, instr.imm};

    // Only decode point for sleep and halt.
    assign is_sleep    = fetch_word.valid && (opcode == op_sleep);
    assign is_halt     = fetch_word.valid && (opcode == op_halt);
    assign redirect_pc = fetch_word.pc + 1'b1;

    // Operands bypass the word in writeback. r0 is hardwired.
    assign op_a = (instr.rs1 == '0) ? '0 :
                  (reg_write.valid && reg_write.rd == instr.rs1) ? reg_write.data :
                  regs[instr.rs1];
    assign rs2_value = (instr.rs2 == '0) ? '0 :
                       (reg_write.valid && reg_write.rd == instr.rs2) ? reg_write.data :
                       regs[instr.rs2];
    assign op_b = (opcode == op_addi) ? imm_ext : rs2_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.valid && reg_write.rd != '0) begin
            regs[reg_write.rd] <= reg_write.data;
        end
    end

    always_comb begin
        alu_result = '0;
        writes_reg = 1'b0;
        case (opcode)
            op_add:  alu_result = op_a + op_b;
            op_sub:  alu_result = op_a - op_b;
            op_and:  alu_result = op_a & op_b;
            op_xor:  alu_result = op_a ^ op_b;
            op_addi: alu_result = op_a + op_b;
            default: alu_result = '0;   // nop, sleep, halt.
        endcase
        if (fetch_word.valid) begin
            writes_reg = opcode inside {op_add, op_sub, op_and, op_xor, op_addi};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_word <= '0;
        end else if (advance) begin
            wb_word.valid <= writes_reg;
            wb_word.rd <= instr.rd;
            wb_word.data <= alu_result;
        end
    end

    // Fetch only ever hands over known opcodes.
    assert property (@(posedge clk) disable iff (reset)
        fetch_word.valid |-> instr.opcode inside {[op_nop:op_halt]});

endmodule

//--- design/writeback_stage.sv
module writeback_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     writeback_advance,
    input  cpu_pkg::wb_word_t        wb_word,
    input  logic [cpu_pkg::XLEN-1:0] pc_in,
    output cpu_pkg::wb_word_t        reg_write,
    output cpu_pkg::retire_t         retire
);
    import cpu_pkg::*;

    logic [XLEN-1:0] exec_pc;
    logic            to_r0;

    assign to_r0 = (wb_word.rd == '0);

    // Register file write for one clock per pulse.
    assign reg_write.valid = writeback_advance && wb_word.valid && !to_r0;
    assign reg_write.rd    = wb_word.rd;
    assign reg_write.data  = wb_word.data;

    // Pc of the word execute registers on the same pulse.
    always_ff @(posedge clk) begin
        if (writeback_advance) begin
            exec_pc <= pc_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire <= '0;
        end else if (writeback_advance) begin
            retire.valid <= wb_word.valid;
            retire.pc <= exec_pc;
            retire.rd <= wb_word.rd;
            retire.data <= to_r0 ? '0 : wb_word.data;
        end else begin
            retire.valid <= 1'b0;   // Single-cycle strobe.
        end
    end

endmodule

//--- design/pipelined_core.sv
module pipelined_core #(
    parameter int CLK_DIV = cpu_pkg::DEFAULT_CLK_DIV
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [15:0]              interrupts,
    output logic [cpu_pkg::XLEN-1:0] imem_addr,
    input  logic [cpu_pkg::XLEN-1:0] imem_data,
    output cpu_pkg::retire_t         retire,
    output logic                     halted,
    output logic                     sleeping,
    output logic [cpu_pkg::XLEN-1:0] cycles
);
    import cpu_pkg::*;

    logic            clk_en;
    logic            advance;
    logic            writeback_advance;
    logic            flush_fetch;
    logic            is_sleep;
    logic            is_halt;
    logic [XLEN-1:0] redirect_pc;
    fetch_word_t     fetch_word;
    wb_word_t        wb_word;
    wb_word_t        reg_write;

    enable_timer #(
        .CLK_DIV (CLK_DIV)
    ) i_timer (
        .clk    (clk),
        .reset  (reset),
        .halted (halted),
        .clk_en (clk_en),
        .cycles (cycles)
    );

    core_control i_control (
        .clk               (clk),
        .reset             (reset),
        .clk_en            (clk_en),
        .is_sleep          (is_sleep),
        .is_halt           (is_halt),
        .interrupts        (interrupts),
        .advance           (advance),
        .writeback_advance (writeback_advance),
        .flush_fetch       (flush_fetch),
        .sleeping          (sleeping),
        .halted            (halted)
    );

    fetch_stage i_fetch (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .flush_fetch (flush_fetch),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fetch_word  (fetch_word)
    );

    execute_stage i_execute (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .fetch_word  (fetch_word),
        .reg_write   (reg_write),
        .wb_word     (wb_word),
        .is_sleep    (is_sleep),
        .is_halt     (is_halt),
        .redirect_pc (redirect_pc)
    );

    writeback_stage i_writeback (
        .clk               (clk),
        .reset             (reset),
        .writeback_advance (writeback_advance),
        .wb_word           (wb_word),
        .pc_in             (fetch_word.pc),
        .reg_write         (reg_write),
        .retire            (retire)
    );

endmodule

//--- testbench/core_checker.sv
module core_checker #(
    parameter int CLK_DIV = 2,
    parameter int MEM_WORDS = 128
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [15:0]              interrupts,
    input  cpu_pkg::retire_t         retire,
    input  logic                     halted,
    input  logic                     sleeping,
    input  logic [cpu_pkg::XLEN-1:0] cycles,
    input  logic [cpu_pkg::XLEN-1:0] program_mem [MEM_WORDS],
    input  logic                     run_end,
    output int                       error_count,
    output logic                     report_done
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    typedef retire_t retire_q_t[$];

    retire_q_t       expected_q;
    int              exp_index;
    int              sleep_pc;
    int              halt_pc;
    int              test_errs [6];
    string           test_names [6] = '{"retire sequence", "r0 targets", "sleep and wake",
                                        "halt and cycles", "retire pacing", "reset state"};
    logic            ready = 1'b0;
    logic            irq_seen = 1'b0;
    logic            was_sleeping = 1'b0;
    logic            woken = 1'b0;
    logic            halt_seen = 1'b0;
    logic [XLEN-1:0] halt_cycles;
    logic [XLEN-1:0] last_pc;
    int              gap;
    int              retire_count;
    int              r0_retires;

    // Runs the program on a model register file and lists each expected retire.
    function automatic retire_q_t reference_run();
        logic [XLEN-1:0] model_regs [NUM_REGS];
        retire_q_t       expected;
        retire_t         entry;
        instr_t          ins;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_ext;
        logic [XLEN-1:0] result;
        logic            is_alu;
        logic            done;
        int              pc;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        pc = 0;
        done = 1'b0;
        while (!done && pc < MEM_WORDS) begin
            ins = instr_t'(program_mem[pc]);
            a = model_regs[ins.rs1];
            b = model_regs[ins.rs2];
            imm_ext = int'($signed(ins.imm));
            result = '0;
            is_alu = 1'b1;
            case (opcode_t'(ins.opcode))
                op_add:  result = a + b;
                op_sub:  result = a - b;
                op_and:  result = a & b;
                op_xor:  result = a ^ b;
                op_addi: result = a + imm_ext;
                op_halt: begin
                    is_alu = 1'b0;
                    done = 1'b1;
                end
                default: is_alu = 1'b0;   // Sleep resumes at the next word.
            endcase
            if (is_alu) begin
                entry.valid = 1'b1;
                entry.pc = XLEN'(pc);
                entry.rd = ins.rd;
                entry.data = result;
                if (ins.rd == '0) begin
                    entry.data = '0;
                end else begin
                    model_regs[ins.rd] = result;
                end
                expected.push_back(entry);
            end
            pc++;
        end
        return expected;
    endfunction

    function automatic int find_pc(opcode_t op);
        instr_t ins;
        for (int pc = 0; pc < MEM_WORDS; pc++) begin
            ins = instr_t'(program_mem[pc]);
            if (ins.opcode == op) begin
                return pc;
            end
        end
        return -1;
    endfunction

    task automatic report_error(int test, string msg);
        test_errs[test]++;
        $display("FAIL %0t ns: %s", $time, msg);
    endtask

    task automatic report_test(int test);
        $display("test %0d %s: %s (%0d errors)", test + 1, test_names[test],
                 (test_errs[test] == 0) ? "passed" : "failed", test_errs[test]);
    endtask

    task automatic check_retire();
        retire_t exp;
        if (retire_count > 0 && gap < CLK_DIV + 1) begin
            report_error(4, $sformatf("retires only %0d cycles apart", gap));
        end
        gap = 0;
        retire_count++;
        last_pc = retire.pc;
        if (retire.rd == '0) begin
            r0_retires++;
            if (retire.data != '0) begin
                report_error(1, $sformatf("r0 retire at pc %0d with data %h", retire.pc,
                                          retire.data));
            end
        end
        if (!irq_seen && retire.pc > sleep_pc) begin
            report_error(2, $sformatf("pc %0d retired before the interrupt", retire.pc));
        end
        if (halt_seen && retire.pc != halt_pc - 1) begin
            report_error(3, $sformatf("pc %0d retired after halt", retire.pc));
        end
        if (exp_index >= expected_q.size()) begin
            report_error(0, $sformatf("extra retire at pc %0d", retire.pc));
        end else begin
            exp = expected_q[exp_index];
            if (retire.pc != exp.pc || retire.rd != exp.rd || retire.data != exp.data) begin
                report_error(0, $sformatf("retire %0d got pc %0d r%0d %h, expected pc %0d r%0d %h",
                                          exp_index, retire.pc, retire.rd, retire.data,
                                          exp.pc, exp.rd, exp.data));
            end
            exp_index++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset && ready && !report_done) begin
            gap++;
            if (interrupts != '0) begin
                irq_seen = 1'b1;
            end
            if (sleeping) begin
                was_sleeping = 1'b1;
            end else if (was_sleeping && !woken) begin
                woken = 1'b1;
                if (!irq_seen) begin
                    report_error(2, "core woke from sleep without an interrupt");
                end
            end
            if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                halt_cycles = cycles;
                // Every retire so far took a pulse of its own.
                if (cycles < XLEN'(retire_count)) begin
                    report_error(3, $sformatf("cycles is %0d at halt after %0d retires",
                                              cycles, retire_count));
                end
            end else if (halt_seen && cycles != halt_cycles) begin
                report_error(3, $sformatf("cycles moved to %0d after halt", cycles));
                halt_cycles = cycles;
            end
            if (retire.valid) begin
                check_retire();
            end
        end
    end

    initial begin
        int passed;
        report_done = 1'b0;
        error_count = 0;
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        expected_q = reference_run();
        sleep_pc = find_pc(op_sleep);
        halt_pc = find_pc(op_halt);
        ready = 1'b1;
        @(posedge clk);
        if (retire.valid || halted || sleeping) begin
            report_error(5, "retire, halted or sleeping high right after reset");
        end
        report_test(5);
        wait (run_end);
        @(posedge clk);
        if (exp_index != expected_q.size()) begin
            report_error(0, $sformatf("only %0d of %0d expected retires were seen",
                                      exp_index, expected_q.size()));
        end
        if (r0_retires == 0) begin
            report_error(1, "no instruction targeting r0 retired");
        end
        if (!was_sleeping || !woken) begin
            report_error(2, "the core did not both enter and leave sleep");
        end
        if (!halt_seen || last_pc != halt_pc - 1) begin
            report_error(3, "halt not reached, or the last retire was not before the halt");
        end
        passed = 0;
        for (int i = 0; i < 6; i++) begin
            if (i < 5) begin
                report_test(i);
            end
            error_count += test_errs[i];
            passed += (test_errs[i] == 0) ? 1 : 0;
        end
        $display("tests: %0d passed, %0d failed, %0d errors", passed, 6 - passed, error_count);
        report_done = 1'b1;
    end

endmodule

//--- testbench/core_tb.sv
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int CLK_DIV = 2;
    localparam int PERIOD = CLK_DIV + 1;
    localparam int ADDR_BITS = 7;
    localparam int MEM_WORDS = 2 ** ADDR_BITS;
    localparam int RESET_CYCLES = 10;
    localparam int ALU_COUNT = 60;
    localparam int SLEEP_AT = 30;           // ALU slot that the sleep goes before.
    localparam int PROG_LEN = ALU_COUNT + 2;
    localparam int SLEEP_WAIT = 20;         // Enable periods before the interrupt.
    localparam int MARGIN = 20;
    localparam int TIMEOUT_CYCLES =
        2 * ((PROG_LEN + SLEEP_WAIT + MARGIN) * PERIOD + RESET_CYCLES);

    logic            clk = 1'b0;
    logic            reset;
    logic [15:0]     interrupts;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_data;
    retire_t         retire;
    logic            halted;
    logic            sleeping;
    logic [XLEN-1:0] cycles;
    logic [XLEN-1:0] imem [MEM_WORDS];
    logic            run_end;
    int              error_count;
    logic            report_done;
    integer          seed;
    int              cycle_count;

    always #2 clk = ~clk;

    // Same-cycle read.
    assign imem_data = (imem_addr < MEM_WORDS) ? imem[imem_addr[ADDR_BITS-1:0]] : '0;

    pipelined_core #(
        .CLK_DIV (CLK_DIV)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .interrupts (interrupts),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .retire     (retire),
        .halted     (halted),
        .sleeping   (sleeping),
        .cycles     (cycles)
    );

    core_checker #(
        .CLK_DIV   (CLK_DIV),
        .MEM_WORDS (MEM_WORDS)
    ) i_checker (
        .clk         (clk),
        .reset       (reset),
        .interrupts  (interrupts),
        .retire      (retire),
        .halted      (halted),
        .sleeping    (sleeping),
        .cycles      (cycles),
        .program_mem (imem),
        .run_end     (run_end),
        .error_count (error_count),
        .report_done (report_done)
    );

    task automatic build_program();
        instr_t              ins;
        opcode_t             alu_ops [5];
        logic [REG_BITS-1:0] prev_rd;
        int                  pc;
        alu_ops = '{op_add, op_sub, op_and, op_xor, op_addi};
        prev_rd = '0;
        pc = 0;
        for (int addr = 0; addr < MEM_WORDS; addr++) begin
            imem[addr] = {5'd0, 27'(addr)};   // Nop with the address in its spare fields.
        end
        for (int n = 0; n < ALU_COUNT; n++) begin
            if (n == SLEEP_AT) begin
                imem[pc] = {op_sleep, 27'd0};
                pc++;
            end
            ins = '0;
            ins.opcode = alu_ops[n % 5];
            ins.rd = 4'($random(seed));
            ins.rs1 = (n % 4 == 1) ? prev_rd : 4'($random(seed));   // Back-to-back use.
            ins.rs2 = (n % 3 == 2) ? prev_rd : 4'($random(seed));
            ins.imm = 12'($random(seed));
            if (n % 9 == 4) begin
                ins.rd = '0;
            end
            imem[pc] = ins;
            prev_rd = ins.rd;
            pc++;
        end
        imem[pc] = {op_halt, 27'd0};
    endtask

    initial begin
        logic [15:0] irq;
        seed = 32'h679e;
        reset = 1'b1;
        interrupts = '0;
        run_end = 1'b0;
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        while (!sleeping) @(negedge clk);
        repeat (SLEEP_WAIT * PERIOD) @(negedge clk);
        irq = 16'($random(seed));
        interrupts = (irq == '0) ? 16'h0001 : irq;
        repeat (PERIOD) @(negedge clk);   // One enable period.
        interrupts = '0;
        while (!halted) @(negedge clk);
        repeat (10 * PERIOD) @(negedge clk);
        run_end = 1'b1;
        wait (report_done);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- list.f
design/cpu_pkg.sv
design/enable_timer.sv
design/core_control.sv
design/fetch_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/pipelined_core.sv
testbench/core_checker.sv
testbench/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f list.f -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
